// ==== hdl/mul_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the multiply unit.
// Widths are fixed: one 32-bit word, split into two halfwords or four
// bytes. The operator encoding is 3 bits and the codes above MUL_DOT16
// are unused. They return zero from the top level.
////////////////////////////////////////////////////////////////////////////

package mul_pkg;

  // Data widths
  localparam int WORD_W  = 32;
  localparam int HALF_W  = 16;
  localparam int BYTE_W  = 8;
  localparam int SHIFT_W = 5;

  // Lane counts of a packed operand word
  localparam int N_BYTE_LANES = WORD_W / BYTE_W;
  localparam int N_HALF_LANES = WORD_W / HALF_W;

  // Width of the 17x17 subword product plus accumulate
  localparam int SMAC_W = 2 * (HALF_W + 1);

  // Busy cycles of the high-half sequence before the result is ready
  localparam int MULH_STEPS = 3;

  // Operator encoding
  typedef enum logic [2:0] {
    MUL_MAC32 = 3'd0,
    MUL_MSU32 = 3'd1,
    MUL_H     = 3'd2,
    MUL_DOT8  = 3'd3,
    MUL_DOT16 = 3'd4
  } mul_op_e;

  // Bit 0 marks operand A as signed, bit 1 marks operand B as signed
  typedef logic [1:0] sign_sel_t;

  // Operand word seen whole or split into byte or halfword lanes
  typedef union packed {
    logic [WORD_W-1:0]                    word;
    logic [N_BYTE_LANES-1:0][BYTE_W-1:0]  lane8;
    logic [N_HALF_LANES-1:0][HALF_W-1:0]  lane16;
  } mul_word_u;

endpackage

// ==== hdl/mul_int_mac.sv ====
////////////////////////////////////////////////////////////////////////////
// 32-bit multiply-accumulate and multiply-subtract, purely combinational.
// Only the low 32 bits are produced, so signedness of the operands does
// not change the result.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_int_mac (
  input  logic                       is_msu_i,
  input  logic [mul_pkg::WORD_W-1:0] op_a_i,
  input  logic [mul_pkg::WORD_W-1:0] op_b_i,
  input  logic [mul_pkg::WORD_W-1:0] op_c_i,
  output logic [mul_pkg::WORD_W-1:0] result_o
);

  import mul_pkg::*;

  logic [WORD_W-1:0] op_a_msu;
  logic [WORD_W-1:0] op_b_msu;
  logic [WORD_W-1:0] product;

  // Subtract without a negator
  // -(A*B) = (~A)*B + B, so invert A and add B once more
  assign op_a_msu = op_a_i ^ {WORD_W{is_msu_i}};
  assign op_b_msu = op_b_i & {WORD_W{is_msu_i}};

  assign product  = op_a_msu * op_b_i;

  // Accumulate with truncation to the word width
  assign result_o = op_c_i + op_b_msu + product;

endmodule

// ==== hdl/mul_short_mac.sv ====
////////////////////////////////////////////////////////////////////////////
// 17x17 signed subword multiply with a 34-bit accumulate and a right shift.
// Each 16-bit lane is extended to 17 bits, by sign or by zero as sign_i
// selects, so unsigned lanes are multiplied exactly.
// With arith_i low the two top sum bits are masked and the shift is
// logical.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_short_mac (
  input  logic                        lane_a_hi_i,
  input  logic                        lane_b_hi_i,
  input  mul_pkg::sign_sel_t          sign_i,
  input  logic [mul_pkg::WORD_W-1:0]  op_a_i,
  input  logic [mul_pkg::WORD_W-1:0]  op_b_i,
  input  logic [mul_pkg::SMAC_W-1:0]  acc_i,
  input  logic [mul_pkg::SHIFT_W-1:0] shift_i,
  input  logic                        arith_i,
  output logic [mul_pkg::SMAC_W-1:0]  sum_o,
  output logic [mul_pkg::SMAC_W-1:0]  result_o
);

  import mul_pkg::*;

  logic [HALF_W-1:0] lane_a;
  logic [HALF_W-1:0] lane_b;
  logic [HALF_W:0]   mul_a;
  logic [HALF_W:0]   mul_b;
  logic [SMAC_W-1:0] product;
  logic [SMAC_W-1:0] sum;
  logic [SMAC_W-1:0] shift_in;

  // Lane selection
  assign lane_a = lane_a_hi_i ? op_a_i[WORD_W-1:HALF_W] : op_a_i[HALF_W-1:0];
  assign lane_b = lane_b_hi_i ? op_b_i[WORD_W-1:HALF_W] : op_b_i[HALF_W-1:0];

  // Extend to 17 bits
  assign mul_a = {sign_i[0] & lane_a[HALF_W-1], lane_a};
  assign mul_b = {sign_i[1] & lane_b[HALF_W-1], lane_b};

  assign product = $signed(mul_a) * $signed(mul_b);
  assign sum     = product + acc_i;

  // Top two bits only survive for an arithmetic shift
  assign shift_in = {arith_i & sum[SMAC_W-1],
                     arith_i & sum[SMAC_W-2],
                     sum[SMAC_W-3:0]};

  assign result_o = $signed(shift_in) >>> shift_i;
  assign sum_o    = sum;

endmodule

// ==== hdl/mulh_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// High-half multiply sequencer, upper 32 bits of a 32x32 product.
// Takes three busy cycles, then holds the result in FINISH until
// ex_ready_i. Operands and signed_i must stay stable the whole time.
// Partial sum and carry are kept here and cleared at the hand-off.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mulh_seq (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start_i,
  input  mul_pkg::sign_sel_t         signed_i,
  input  logic [mul_pkg::WORD_W-1:0] op_a_i,
  input  logic [mul_pkg::WORD_W-1:0] op_b_i,
  input  logic                       ex_ready_i,
  output logic [mul_pkg::WORD_W-1:0] result_o,
  output logic                       ready_o,
  output logic                       multicycle_o
);

  import mul_pkg::*;

  typedef enum logic [2:0] {IDLE, STEP0, STEP1, STEP2, FINISH} mulh_state_e;

  mulh_state_e        state_q;
  mulh_state_e        state_d;
  logic [WORD_W-1:0]  partial_q;
  logic               carry_q;

  logic               lane_a_hi;
  logic               lane_b_hi;
  sign_sel_t          step_sign;
  logic [SHIFT_W-1:0] step_shift;
  logic               step_arith;
  logic [SMAC_W-1:0]  step_acc;
  logic               save_partial;
  logic               save_carry;
  logic               clear_carry;
  logic               handoff;
  logic [SMAC_W-1:0]  mac_sum;
  logic [SMAC_W-1:0]  mac_result;

  mul_short_mac u_short_mac (
    .lane_a_hi_i (lane_a_hi),
    .lane_b_hi_i (lane_b_hi),
    .sign_i      (step_sign),
    .op_a_i      (op_a_i),
    .op_b_i      (op_b_i),
    .acc_i       (step_acc),
    .shift_i     (step_shift),
    .arith_i     (step_arith),
    .sum_o       (mac_sum),
    .result_o    (mac_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Step control
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d      = state_q;
    lane_a_hi    = 1'b0;
    lane_b_hi    = 1'b0;
    step_sign    = 2'b00;
    step_shift   = '0;
    step_arith   = 1'b0;
    // Partial with the saved carry as its sign
    step_acc     = {{(SMAC_W-WORD_W){carry_q}}, partial_q};
    save_partial = 1'b0;
    save_carry   = 1'b0;
    clear_carry  = 1'b0;
    handoff      = 1'b0;
    ready_o      = 1'b0;
    multicycle_o = 1'b0;

    case (state_q)
      IDLE: begin
        ready_o = 1'b1;
        if (start_i) begin
          ready_o = 1'b0;
          state_d = STEP0;
        end
      end
      STEP0: begin
        // AL*BL is always unsigned and never overflows
        multicycle_o = 1'b1;
        step_acc     = '0;
        step_shift   = SHIFT_W'(HALF_W);
        save_partial = 1'b1;
        state_d      = STEP1;
      end
      STEP1: begin
        // AL*BH is signed only if B is
        // Sum bit 32 is kept as the carry
        multicycle_o = 1'b1;
        lane_b_hi    = 1'b1;
        step_sign    = {signed_i[1], 1'b0};
        step_arith   = 1'b1;
        save_partial = 1'b1;
        save_carry   = 1'b1;
        state_d      = STEP2;
      end
      STEP2: begin
        // AH*BL is signed only if A is
        // Bits above 32 are shifted back in, so the carry goes away
        multicycle_o = 1'b1;
        lane_a_hi    = 1'b1;
        step_sign    = {1'b0, signed_i[0]};
        step_shift   = SHIFT_W'(HALF_W);
        step_arith   = 1'b1;
        save_partial = 1'b1;
        save_carry   = 1'b1;
        clear_carry  = 1'b1;
        state_d      = FINISH;
      end
      FINISH: begin
        lane_a_hi = 1'b1;
        lane_b_hi = 1'b1;
        step_sign = signed_i;
        ready_o   = 1'b1;
        if (ex_ready_i) begin
          handoff = 1'b1;
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      partial_q <= '0;
      carry_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      if (save_partial) begin
        partial_q <= mac_result[WORD_W-1:0];
      end else if (handoff) begin
        partial_q <= '0;
      end
      if (save_carry) begin
        carry_q <= ~clear_carry & mac_sum[WORD_W];
      end else if (handoff) begin
        carry_q <= 1'b0;
      end
    end
  end

  assign result_o = mac_result[WORD_W-1:0];

endmodule

// ==== hdl/mul_dot_unit.sv ====
////////////////////////////////////////////////////////////////////////////
// Byte and halfword dot products with accumulate, combinational.
// signed_i applies to every lane of an operand alike.
// Results wrap to 32 bits.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_dot_unit (
  input  mul_pkg::sign_sel_t         signed_i,
  input  mul_pkg::mul_word_u         op_a_i,
  input  mul_pkg::mul_word_u         op_b_i,
  input  logic [mul_pkg::WORD_W-1:0] op_c_i,
  output logic [mul_pkg::WORD_W-1:0] dot8_o,
  output logic [mul_pkg::WORD_W-1:0] dot16_o
);

  import mul_pkg::*;

  logic [N_BYTE_LANES-1:0][BYTE_W:0]       byte_a;
  logic [N_BYTE_LANES-1:0][BYTE_W:0]       byte_b;
  logic [N_BYTE_LANES-1:0][2*BYTE_W+1:0]   byte_mul;
  logic signed [WORD_W-1:0]                dot8_sum;

  logic [N_HALF_LANES-1:0][HALF_W:0]       half_a;
  logic [N_HALF_LANES-1:0][HALF_W:0]       half_b;
  logic [N_HALF_LANES-1:0][2*HALF_W+1:0]   half_mul;
  logic signed [WORD_W-1:0]                dot16_sum;

  ////////////////////////////////////////////////////////////////////////////
  // Byte lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dot8_sum = op_c_i;
    for (int i = 0; i < N_BYTE_LANES; i++) begin
      byte_a[i]   = {signed_i[0] & op_a_i.lane8[i][BYTE_W-1], op_a_i.lane8[i]};
      byte_b[i]   = {signed_i[1] & op_b_i.lane8[i][BYTE_W-1], op_b_i.lane8[i]};
      byte_mul[i] = $signed(byte_a[i]) * $signed(byte_b[i]);
      // Sign-extended into the running sum
      dot8_sum    = dot8_sum + $signed(byte_mul[i]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Halfword lanes
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dot16_sum = op_c_i;
    for (int i = 0; i < N_HALF_LANES; i++) begin
      half_a[i]   = {signed_i[0] & op_a_i.lane16[i][HALF_W-1], op_a_i.lane16[i]};
      half_b[i]   = {signed_i[1] & op_b_i.lane16[i][HALF_W-1], op_b_i.lane16[i]};
      half_mul[i] = $signed(half_a[i]) * $signed(half_b[i]);
      // Only the low word of each product reaches the result
      dot16_sum   = dot16_sum + $signed(half_mul[i][WORD_W-1:0]);
    end
  end

  assign dot8_o  = dot8_sum;
  assign dot16_o = dot16_sum;

endmodule

// ==== hdl/mul_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Multiply unit top level: MAC/MSU, high-half multiply and dot products.
// All operators except MUL_H finish in the cycle they are issued.
// MUL_H holds ready_o low for three cycles after acceptance. The core must
// keep operator, signs and operands stable until ready_o with ex_ready_i.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module mul_top (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable_i,
  input  mul_pkg::mul_op_e           operator_i,
  input  mul_pkg::sign_sel_t         signed_i,
  input  logic [mul_pkg::WORD_W-1:0] op_a_i,
  input  logic [mul_pkg::WORD_W-1:0] op_b_i,
  input  logic [mul_pkg::WORD_W-1:0] op_c_i,
  input  logic                       ex_ready_i,
  output logic [mul_pkg::WORD_W-1:0] result_o,
  output logic                       ready_o,
  output logic                       multicycle_o
);

  import mul_pkg::*;

  logic              is_msu;
  logic              mulh_start;
  mul_word_u         dot_a;
  mul_word_u         dot_b;
  logic [WORD_W-1:0] int_result;
  logic [WORD_W-1:0] mulh_result;
  logic [WORD_W-1:0] dot8_result;
  logic [WORD_W-1:0] dot16_result;

  // Operator decode
  assign is_msu     = (operator_i == MUL_MSU32);
  assign mulh_start = enable_i && (operator_i == MUL_H);

  ////////////////////////////////////////////////////////////////////////////
  // Datapaths
  ////////////////////////////////////////////////////////////////////////////

  mul_int_mac u_int_mac (
    .is_msu_i (is_msu),
    .op_a_i   (op_a_i),
    .op_b_i   (op_b_i),
    .op_c_i   (op_c_i),
    .result_o (int_result)
  );

  mulh_seq u_mulh_seq (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (mulh_start),
    .signed_i     (signed_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .ex_ready_i   (ex_ready_i),
    .result_o     (mulh_result),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  // Dot unit sees the operands as packed lanes
  assign dot_a.word = op_a_i;
  assign dot_b.word = op_b_i;

  mul_dot_unit u_dot_unit (
    .signed_i (signed_i),
    .op_a_i   (dot_a),
    .op_b_i   (dot_b),
    .op_c_i   (op_c_i),
    .dot8_o   (dot8_result),
    .dot16_o  (dot16_result)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      MUL_MAC32, MUL_MSU32: result_o = int_result;
      MUL_H:                result_o = mulh_result;
      MUL_DOT8:             result_o = dot8_result;
      MUL_DOT16:            result_o = dot16_result;
      // Unused codes
      default:              result_o = '0;
    endcase
  end

endmodule

// ==== sim/mul_model.svh ====
////////////////////////////////////////////////////////////////////////////
// Reference model of the multiply unit, one function per operator.
// Every product is formed at 64 bits from the extended operands and only
// then cut to the word width. Included inside the testbench module after
// the mul_pkg import, so the package names are visible here.
////////////////////////////////////////////////////////////////////////////

`ifndef MUL_MODEL_SVH
`define MUL_MODEL_SVH

  // Sign or zero extension of the low width bits of a lane to 64 bits
  function automatic logic [63:0] extend_lane(logic [WORD_W-1:0] lane, int width,
                                              logic is_signed);
    logic [63:0] ext;
    ext = {32'b0, lane};
    for (int i = width; i < 64; i++) begin
      ext[i] = is_signed & lane[width-1];
    end
    return ext;
  endfunction

  // Low word of op_c plus or minus op_a times op_b
  function automatic logic [WORD_W-1:0] mac_word(logic [WORD_W-1:0] a, logic [WORD_W-1:0] b,
                                                 logic [WORD_W-1:0] c, logic subtract);
    logic [63:0] prod;
    prod = {32'b0, a} * {32'b0, b};
    return subtract ? c - prod[WORD_W-1:0] : c + prod[WORD_W-1:0];
  endfunction

  // Upper half of the 64-bit product
  function automatic logic [WORD_W-1:0] high_half(logic [WORD_W-1:0] a, logic [WORD_W-1:0] b,
                                                  sign_sel_t sgn);
    logic [63:0] prod;
    prod = extend_lane(a, WORD_W, sgn[0]) * extend_lane(b, WORD_W, sgn[1]);
    return prod[63:WORD_W];
  endfunction

  // Four byte lane products summed onto op_c
  function automatic logic [WORD_W-1:0] byte_dot(mul_word_u a, mul_word_u b,
                                                 logic [WORD_W-1:0] c, sign_sel_t sgn);
    logic [63:0] sum;
    sum = {32'b0, c};
    for (int i = 0; i < N_BYTE_LANES; i++) begin
      sum = sum + extend_lane(WORD_W'(a.lane8[i]), BYTE_W, sgn[0])
                * extend_lane(WORD_W'(b.lane8[i]), BYTE_W, sgn[1]);
    end
    return sum[WORD_W-1:0];
  endfunction

  // Two halfword lane products summed onto op_c
  function automatic logic [WORD_W-1:0] half_dot(mul_word_u a, mul_word_u b,
                                                 logic [WORD_W-1:0] c, sign_sel_t sgn);
    logic [63:0] sum;
    sum = {32'b0, c};
    for (int i = 0; i < N_HALF_LANES; i++) begin
      sum = sum + extend_lane(WORD_W'(a.lane16[i]), HALF_W, sgn[0])
                * extend_lane(WORD_W'(b.lane16[i]), HALF_W, sgn[1]);
    end
    return sum[WORD_W-1:0];
  endfunction

`endif

// ==== sim/tb_mul_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the multiply unit with random operators and operands.
// Inputs change 2 ns after the rising edge, outputs are sampled 1 ns later.
// MUL_H uses only the sign pairs 00, 01 and 11. Back-pressure is applied
// for 0 to 3 cycles in FINISH.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_mul_top;

  import mul_pkg::*;

  `include "mul_model.svh"

  localparam int          N_OPS          = 2000;
  localparam int          TIMEOUT_CYCLES = N_OPS * 8 + 100;
  localparam logic [15:0] LFSR_SEED      = 16'd37727;
  localparam logic [15:0] LFSR_TAPS      = 16'hB400;

  logic              clk;
  logic              rst_n;
  logic              enable_i;
  mul_op_e           operator_i;
  sign_sel_t         signed_i;
  logic [WORD_W-1:0] op_a_i;
  logic [WORD_W-1:0] op_b_i;
  logic [WORD_W-1:0] op_c_i;
  logic              ex_ready_i;
  logic [WORD_W-1:0] result_o;
  logic              ready_o;
  logic              multicycle_o;

  logic [15:0]       lfsr_q;
  int                cycle_count;

  mul_top UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (enable_i),
    .operator_i   (operator_i),
    .signed_i     (signed_i),
    .op_a_i       (op_a_i),
    .op_b_i       (op_b_i),
    .op_c_i       (op_c_i),
    .ex_ready_i   (ex_ready_i),
    .result_o     (result_o),
    .ready_o      (ready_o),
    .multicycle_o (multicycle_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Random bits and checks
  ////////////////////////////////////////////////////////////////////////////

  // Galois step that returns the bit shifted out
  function automatic logic lfsr_step();
    logic out_bit;
    out_bit = lfsr_q[0];
    lfsr_q  = lfsr_q >> 1;
    if (out_bit) begin
      lfsr_q = lfsr_q ^ LFSR_TAPS;
    end
    return out_bit;
  endfunction

  function automatic logic [WORD_W-1:0] rand_bits(int n);
    logic [WORD_W-1:0] value;
    value = '0;
    for (int i = 0; i < n; i++) begin
      value = {value[WORD_W-2:0], lfsr_step()};
    end
    return value;
  endfunction

  task automatic check_value(string name, logic [WORD_W-1:0] expected,
                             logic [WORD_W-1:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h",
               $time, name, expected, actual);
      $display("Simulation finished: FAIL");
      $fatal(1, "Wrong value on %s", name);
    end
  endtask

  // Apply one operation after the edge and let the outputs settle
  task automatic drive_op(mul_op_e op, sign_sel_t sgn, logic [WORD_W-1:0] a,
                          logic [WORD_W-1:0] b, logic [WORD_W-1:0] c, logic ex_rdy);
    @(posedge clk);
    #2;
    enable_i   = 1'b1;
    operator_i = op;
    signed_i   = sgn;
    op_a_i     = a;
    op_b_i     = b;
    op_c_i     = c;
    ex_ready_i = ex_rdy;
    #1;
  endtask

  task automatic run_item();
    mul_op_e           op;
    sign_sel_t         sgn;
    logic [WORD_W-1:0] a;
    logic [WORD_W-1:0] b;
    logic [WORD_W-1:0] c;
    logic [WORD_W-1:0] expected;
    logic [WORD_W-1:0] held;
    logic [2:0]        sel;
    int                stall;
    int                busy;
    sel   = 3'(rand_bits(3));
    op    = mul_op_e'(sel % 3'd5);
    sgn   = sign_sel_t'(rand_bits(2));
    a     = rand_bits(WORD_W);
    b     = rand_bits(WORD_W);
    c     = rand_bits(WORD_W);
    stall = int'(rand_bits(2));
    if (op == MUL_H) begin
      // Signed/signed, signed/unsigned or unsigned/unsigned
      sgn = (sgn == 2'b10) ? 2'b11 : sgn;
    end
    case (op)
      MUL_MAC32: expected = mac_word(a, b, c, 1'b0);
      MUL_MSU32: expected = mac_word(a, b, c, 1'b1);
      MUL_H:     expected = high_half(a, b, sgn);
      MUL_DOT8:  expected = byte_dot(a, b, c, sgn);
      default:   expected = half_dot(a, b, c, sgn);
    endcase
    if (op != MUL_H) begin
      drive_op(op, sgn, a, b, c, 1'b1);
      check_value("ready_o", WORD_W'(1'b1), WORD_W'(ready_o));
      check_value("multicycle_o", WORD_W'(1'b0), WORD_W'(multicycle_o));
      check_value("result_o", expected, result_o);
    end else begin
      drive_op(op, sgn, a, b, c, stall == 0);
      check_value("ready_o", WORD_W'(1'b0), WORD_W'(ready_o));
      busy = 0;
      @(posedge clk);
      #3;
      while (!ready_o) begin
        check_value("multicycle_o", WORD_W'(1'b1), WORD_W'(multicycle_o));
        busy++;
        @(posedge clk);
        #3;
      end
      assert (busy == MULH_STEPS) else begin
        $display("MUL_H kept ready_o low for %0d cycles instead of %0d", busy, MULH_STEPS);
        $display("Simulation finished: FAIL");
        $fatal(1, "MUL_H busy time is wrong");
      end
      check_value("multicycle_o", WORD_W'(1'b0), WORD_W'(multicycle_o));
      check_value("result_o", expected, result_o);
      held = result_o;
      // FINISH must hold while the core stalls
      while (stall > 0) begin
        @(posedge clk);
        #2;
        stall--;
        ex_ready_i = (stall == 0);
        #1;
        check_value("ready_o", WORD_W'(1'b1), WORD_W'(ready_o));
        check_value("result_o", held, result_o);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    lfsr_q     = LFSR_SEED;
    rst_n      = 1'b0;
    enable_i   = 1'b0;
    operator_i = MUL_MAC32;
    signed_i   = 2'b00;
    op_a_i     = '0;
    op_b_i     = '0;
    op_c_i     = '0;
    ex_ready_i = 1'b1;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    #1;
    check_value("ready_o", WORD_W'(1'b1), WORD_W'(ready_o));
    check_value("multicycle_o", WORD_W'(1'b0), WORD_W'(multicycle_o));
    for (int n = 0; n < N_OPS; n++) begin
      run_item();
    end
    $display("Simulation finished: PASS");
    $finish;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the operations did not complete within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $fatal(1, "Run stopped by the cycle limit");
  end

endmodule

// ==== src.f ====
+incdir+sim
hdl/mul_pkg.sv
hdl/mul_int_mac.sv
hdl/mul_short_mac.sv
hdl/mulh_seq.sv
hdl/mul_dot_unit.sv
hdl/mul_top.sv
sim/tb_mul_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the multiply unit testbench with Verilator.
# The exit status is the simulator's: nonzero when the testbench fails.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir

verilator --binary --timing -Wno-fatal \
  --top-module tb_mul_top \
  -Mdir obj_dir \
  -f src.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_mul_top
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi

exit 0
